//--- design/rfrw_pkg.sv
// sizes and request structs shared by the register file access RTL and its testbench
// only the low AWIDTH bits of a configuration address ever reach the RAM
package rfrw_pkg;

  localparam int DEPTH      = 64;
  localparam int DWIDTH     = 24;
  localparam int PAR_BITS   = 2;
  localparam int AWIDTH     = $clog2(DEPTH);
  localparam int CFG_AWIDTH = 20;
  localparam int BIT_IDX_W  = 12;
  localparam int CFG_DWIDTH = 32;
  localparam int CC_VWIDTH  = 8;
  localparam int CC_WWIDTH  = 4;

  typedef struct packed {
    logic              re;
    logic              we;
    logic [AWIDTH-1:0] addr;
    logic [DWIDTH-1:0] wdata;
  } func_req_t;

  // the init walker issues requests in exactly the functional format
  typedef func_req_t init_req_t;

  typedef struct packed {
    logic                  re;
    logic                  we;
    logic [CFG_AWIDTH-1:0] addr;
    logic [BIT_IDX_W-1:0]  minbit;
    logic [BIT_IDX_W-1:0]  maxbit;
    logic [CFG_DWIDTH-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                 v;
    logic [CC_VWIDTH-1:0] value;
    logic [CC_WWIDTH-1:0] width;
    logic [BIT_IDX_W-1:0] position;
  } cc_req_t;

  typedef struct packed {
    logic              re;
    logic              we;
    logic [AWIDTH-1:0] raddr;
    logic [AWIDTH-1:0] waddr;
    logic [DWIDTH-1:0] wdata;
  } mem_req_t;

endpackage

//--- design/rfrw_ram.sv
// one read port, one write port, both on clk
// a read of the address being written returns the old word
// contents are unknown until the init walk has run
`timescale 1ns/1ps

module rfrw_ram
  import rfrw_pkg::*;
(
  input  logic                       clk,
  input  logic                       we,
  input  logic [AWIDTH-1:0]          waddr,
  input  logic [DWIDTH+PAR_BITS-1:0] wdata,
  input  logic                       re,
  input  logic [AWIDTH-1:0]          raddr,
  output logic [DWIDTH+PAR_BITS-1:0] rdata
);

  logic [DWIDTH+PAR_BITS-1:0] mem_array [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem_array[waddr] <= wdata;
    end
  end

  // output register holds its last value while re is low
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem_array[raddr];
    end
  end

endmodule

//--- design/rfrw_parity.sv
// interleaved even parity between the access block and the RAM
// detection only, a bad word is passed through unchanged
`timescale 1ns/1ps

module rfrw_parity
  import rfrw_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  mem_req_t                   mem,
  input  logic                       err_inject,
  input  logic [DWIDTH+PAR_BITS-1:0] ram_rdata,
  output logic                       ram_we,
  output logic                       ram_re,
  output logic [AWIDTH-1:0]          ram_waddr,
  output logic [AWIDTH-1:0]          ram_raddr,
  output logic [DWIDTH+PAR_BITS-1:0] ram_wdata,
  output logic [DWIDTH-1:0]          rdata,
  output logic                       rdata_error
);

  logic [PAR_BITS-1:0] wpar;
  logic                rd_pend_q;

  // bit k covers every data bit whose index mod PAR_BITS is k
  function automatic logic [PAR_BITS-1:0] calc_par(input logic [DWIDTH-1:0] d);
    logic [PAR_BITS-1:0] p;
    p = '0;
    for (int i = 0; i < DWIDTH; i++) begin
      p[i % PAR_BITS] = p[i % PAR_BITS] ^ d[i];
    end
    return p;
  endfunction

  // injection flips parity bit 0 of the word being written
  assign wpar      = calc_par(mem.wdata) ^ PAR_BITS'(err_inject);
  assign ram_wdata = {wpar, mem.wdata};
  assign ram_we    = mem.we;
  assign ram_re    = mem.re;
  assign ram_waddr = mem.waddr;
  assign ram_raddr = mem.raddr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem.re;
    end
  end

  // the RAM output is already registered, so the check lands in the data cycle
  assign rdata       = ram_rdata[DWIDTH-1:0];
  assign rdata_error = rd_pend_q & (ram_rdata[DWIDTH +: PAR_BITS] != calc_par(rdata));

endmodule

//--- design/rfrw_init_seq.sv
// power-fail init walker, one zero write per cycle from address 0 upward
// a start strobe during the walk is ignored
// there is no back-pressure, the walk wins over functional traffic
`timescale 1ns/1ps

module rfrw_init_seq
  import rfrw_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      init_start,
  output init_req_t init,
  output logic      init_busy,
  output logic      init_done
);

  logic [AWIDTH-1:0] addr_q;
  logic              busy_q;
  logic              done_q;
  logic              last;

  assign last = (addr_q == AWIDTH'(DEPTH - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      // done pulses for one cycle right after the last write
      done_q <= busy_q & last;
      if (!busy_q) begin
        if (init_start) begin
          busy_q <= 1'b1;
          addr_q <= '0;
        end
      end else begin
        addr_q <= addr_q + AWIDTH'(1);
        if (last) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    init.re    = 1'b0;
    init.we    = busy_q;
    init.addr  = addr_q;
    init.wdata = '0;
  end

  assign init_busy = busy_q;
  assign init_done = done_q;

endmodule

//--- design/rfrw_access.sv
// request selection and configuration field pipeline for the register file
// collisions are only flagged on error, never resolved by stalling a client
// a config write owns the RAM write port in its ack cycle, clients must keep clear
`timescale 1ns/1ps

module rfrw_access
  import rfrw_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  func_req_t             func,
  input  init_req_t             init,
  input  cfg_req_t              cfg,
  input  cc_req_t               cc,
  input  logic [DWIDTH-1:0]     rdata,
  output mem_req_t              mem,
  output logic [DWIDTH-1:0]     func_rdata,
  output logic [DWIDTH-1:0]     init_rdata,
  output logic [CFG_DWIDTH-1:0] cfg_rdata,
  output logic                  cfg_ack,
  output logic                  error
);

  // stage control, reset
  logic s1_re;
  logic s1_we;
  logic s2_re;
  logic s2_we;
  logic error_q;

  // stage payload, no reset
  cfg_req_t          cfg_s1;
  cc_req_t           cc_s1;
  cfg_req_t          cfg_s2;
  cc_req_t           cc_s2;
  logic [DWIDTH-1:0] rword_s2;

  logic [5:0]            strobes;
  logic [CFG_DWIDTH-1:0] rd_mask;
  logic [CFG_DWIDTH-1:0] rd_shift;
  logic [DWIDTH-1:0]     fld_mask;
  logic [DWIDTH-1:0]     cc_mask;
  logic [DWIDTH-1:0]     fld_data;
  logic [DWIDTH-1:0]     cc_data;
  logic [DWIDTH-1:0]     merged;

  function automatic mem_req_t client_req(input func_req_t r);
    mem_req_t m;
    m.re    = r.re;
    m.we    = r.we;
    m.raddr = r.addr;
    m.waddr = r.addr;
    m.wdata = r.wdata;
    return m;
  endfunction

  // ----------------------------------------------------------------------
  // request selection, later assignments win so config has top priority
  // ----------------------------------------------------------------------
  always_comb begin
    mem = '0;
    if (func.re || func.we) begin
      mem = client_req(func);
    end
    if (init.re || init.we) begin
      mem = client_req(init);
    end
    // config always starts with a read of the target word
    if (cfg.re || cfg.we) begin
      mem.re    = 1'b1;
      mem.we    = 1'b0;
      mem.raddr = cfg.addr[AWIDTH-1:0];
      mem.waddr = cfg.addr[AWIDTH-1:0];
      mem.wdata = '0;
    end
    // write back of a read-modify-write in its ack cycle
    if (s2_we) begin
      mem.we    = 1'b1;
      mem.waddr = cfg_s2.addr[AWIDTH-1:0];
      mem.wdata = merged;
    end
  end

  // every reader sees the same word, each knows when its own data is valid
  assign func_rdata = rdata;
  assign init_rdata = rdata;

  // ----------------------------------------------------------------------
  // configuration pipeline: capture, read return, merge and answer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_re <= 1'b0;
      s1_we <= 1'b0;
      s2_re <= 1'b0;
      s2_we <= 1'b0;
    end else begin
      s1_re <= cfg.re;
      s1_we <= cfg.we;
      s2_re <= s1_re;
      s2_we <= s1_we;
    end
  end

  always_ff @(posedge clk) begin
    if (cfg.re || cfg.we) begin
      cfg_s1 <= cfg;
      cc_s1  <= cc;
    end
    if (s1_re || s1_we) begin
      cfg_s2   <= cfg_s1;
      cc_s2    <= cc_s1;
      rword_s2 <= rdata;
    end
  end

  // field and check-code masks over the stored word
  always_comb begin
    fld_mask = '0;
    cc_mask  = '0;
    for (int i = 0; i < DWIDTH; i++) begin
      if (i >= int'(cfg_s2.minbit) && i <= int'(cfg_s2.maxbit)) begin
        fld_mask[i] = 1'b1;
      end
      if (cc_s2.v && i >= int'(cc_s2.position) &&
          i < int'(cc_s2.position) + int'(cc_s2.width)) begin
        cc_mask[i] = 1'b1;
      end
    end
    // read mask is right-aligned, width maxbit-minbit+1
    for (int j = 0; j < CFG_DWIDTH; j++) begin
      rd_mask[j] = (j <= int'(cfg_s2.maxbit) - int'(cfg_s2.minbit));
    end
  end

  assign rd_shift  = CFG_DWIDTH'(rword_s2 >> cfg_s2.minbit);
  assign cfg_rdata = s2_re ? (rd_shift & rd_mask) : '0;
  assign cfg_ack   = s2_re | s2_we;

  // check code is merged after the data field so it wins on overlap
  assign fld_data = (DWIDTH'(cfg_s2.wdata) << cfg_s2.minbit) & fld_mask;
  assign cc_data  = (DWIDTH'(cc_s2.value) << cc_s2.position) & cc_mask;
  assign merged   = (((rword_s2 & ~fld_mask) | fld_data) & ~cc_mask) | cc_data;

  // ----------------------------------------------------------------------
  // collision error, set when more than one strobe was high
  // ----------------------------------------------------------------------
  assign strobes = {func.re, func.we, init.re, init.we, cfg.re, cfg.we};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_q <= 1'b0;
    end else begin
      error_q <= |(strobes & (strobes - 6'd1));
    end
  end

  assign error = error_q;

endmodule

//--- design/rfrw_top.sv
// register file subsystem with functional, config and init access
// clients must avoid colliding strobes, error only reports them
// config field indices above DWIDTH-1 read as zero and write nothing
`timescale 1ns/1ps

module rfrw_top
  import rfrw_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  func_req_t             func,
  input  cfg_req_t              cfg,
  input  cc_req_t               cc,
  input  logic                  init_start,
  input  logic                  err_inject,
  output logic [DWIDTH-1:0]     func_rdata,
  output logic [DWIDTH-1:0]     init_rdata,
  output logic [CFG_DWIDTH-1:0] cfg_rdata,
  output logic                  cfg_ack,
  output logic                  init_busy,
  output logic                  init_done,
  output logic                  rdata_error,
  output logic                  error
);

  init_req_t                  init_req;
  mem_req_t                   mem_req;
  logic [DWIDTH-1:0]          rdata;
  logic                       ram_we;
  logic                       ram_re;
  logic [AWIDTH-1:0]          ram_waddr;
  logic [AWIDTH-1:0]          ram_raddr;
  logic [DWIDTH+PAR_BITS-1:0] ram_wdata;
  logic [DWIDTH+PAR_BITS-1:0] ram_rdata;

  rfrw_init_seq u_init_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .init_start (init_start),
    .init       (init_req),
    .init_busy  (init_busy),
    .init_done  (init_done)
  );

  rfrw_access u_access (
    .clk        (clk),
    .rst_n      (rst_n),
    .func       (func),
    .init       (init_req),
    .cfg        (cfg),
    .cc         (cc),
    .rdata      (rdata),
    .mem        (mem_req),
    .func_rdata (func_rdata),
    .init_rdata (init_rdata),
    .cfg_rdata  (cfg_rdata),
    .cfg_ack    (cfg_ack),
    .error      (error)
  );

  rfrw_parity u_parity (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem         (mem_req),
    .err_inject  (err_inject),
    .ram_rdata   (ram_rdata),
    .ram_we      (ram_we),
    .ram_re      (ram_re),
    .ram_waddr   (ram_waddr),
    .ram_raddr   (ram_raddr),
    .ram_wdata   (ram_wdata),
    .rdata       (rdata),
    .rdata_error (rdata_error)
  );

  rfrw_ram u_ram (
    .clk   (clk),
    .we    (ram_we),
    .waddr (ram_waddr),
    .wdata (ram_wdata),
    .re    (ram_re),
    .raddr (ram_raddr),
    .rdata (ram_rdata)
  );

endmodule

//--- verif/rfrw_assertions.sv
// request protocol checks for the access block, attached by bind
// all checks are disabled while rst_n is low
// fail_count is read by the testbench at the end of the run
`timescale 1ns/1ps

module rfrw_assertions
  import rfrw_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input func_req_t func,
  input init_req_t init,
  input cfg_req_t  cfg,
  input logic      cfg_ack,
  input logic      error
);

  int   fail_count = 0;
  logic cfg_req;
  logic other_req;
  logic collide;

  assign cfg_req   = cfg.re | cfg.we;
  assign other_req = func.re | func.we | init.re | init.we;
  assign collide   = $countones({func.re, func.we, init.re, init.we, cfg.re, cfg.we}) > 1;

  // ----------------------------------------------------------------------
  // config answer timing
  // ----------------------------------------------------------------------
  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_req |-> ##2 cfg_ack)
    else begin
      $error("cfg_ack missing two cycles after a config request");
      fail_count++;
    end

  ack_only_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_ack |-> $past(cfg_req, 2))
    else begin
      $error("cfg_ack without a config request two cycles before");
      fail_count++;
    end

  // error reflects the strobe count of the previous cycle
  error_on_collision: assert property (@(posedge clk) disable iff (!rst_n)
    error == $past(collide))
    else begin
      $error("error does not match the collision of the previous cycle");
      fail_count++;
    end

  // ----------------------------------------------------------------------
  // client rules around a config write
  // ----------------------------------------------------------------------
  write_ack_cycle_free: assert property (@(posedge clk) disable iff (!rst_n)
    $past(cfg.we, 2) |-> !other_req)
    else begin
      $error("functional or init strobe in a config write ack cycle");
      fail_count++;
    end

  write_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    cfg.we |=> !cfg_req [*2])
    else begin
      $error("config request within two cycles of a config write");
      fail_count++;
    end

endmodule

bind rfrw_access rfrw_assertions u_assertions (
  .clk     (clk),
  .rst_n   (rst_n),
  .func    (func),
  .init    (init),
  .cfg     (cfg),
  .cfg_ack (cfg_ack),
  .error   (error)
);

//--- verif/rfrw_tb.sv
// testbench for the register file subsystem
// a shadow array predicts every word
// config field writes keep the data field in bits 0..11 and the check code above
// protocol timing is checked by the bound assertions
`timescale 1ns/1ps

module rfrw_tb
  import rfrw_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;
  localparam int N_FUNC     = 16;
  localparam int N_CFG_RD   = 16;
  localparam int N_CFG_WR   = 16;
  // the watchdog allows twice this rough cycle count of all tests
  localparam int TEST_CYCLES = RST_CYCLES + DEPTH + 4 + N_FUNC * 3 + N_FUNC * 5
                             + N_CFG_RD + 4 + N_CFG_WR * 6 + 10 + 12 + 8;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  logic                  clk;
  logic                  rst_n;
  func_req_t             func;
  cfg_req_t              cfg;
  cc_req_t               cc;
  logic                  init_start;
  logic                  err_inject;
  logic [DWIDTH-1:0]     func_rdata;
  logic [DWIDTH-1:0]     init_rdata;
  logic [CFG_DWIDTH-1:0] cfg_rdata;
  logic                  cfg_ack;
  logic                  init_busy;
  logic                  init_done;
  logic                  rdata_error;
  logic                  error;

  logic [DWIDTH-1:0] shadow [DEPTH];
  int                seed   = 22;
  int                errors = 0;
  int                assert_fails;

  rfrw_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .func        (func),
    .cfg         (cfg),
    .cc          (cc),
    .init_start  (init_start),
    .err_inject  (err_inject),
    .func_rdata  (func_rdata),
    .init_rdata  (init_rdata),
    .cfg_rdata   (cfg_rdata),
    .cfg_ack     (cfg_ack),
    .init_busy   (init_busy),
    .init_done   (init_done),
    .rdata_error (rdata_error),
    .error       (error)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // ----------------------------------------------------------------------
  // reference model and helpers
  // ----------------------------------------------------------------------
  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % (hi - lo + 1));
  endfunction

  // right-aligned copy of bits hi down to lo
  function automatic logic [CFG_DWIDTH-1:0] field_bits(input logic [DWIDTH-1:0] w,
                                                       input int lo, input int hi);
    logic [CFG_DWIDTH-1:0] f;
    f = '0;
    for (int i = lo; i <= hi; i++) begin
      f[i - lo] = w[i];
    end
    return f;
  endfunction

  function automatic logic [DWIDTH-1:0] merged_word(input logic [DWIDTH-1:0] old,
                                                    input cfg_req_t r, input cc_req_t c);
    logic [DWIDTH-1:0] w;
    w = old;
    for (int i = int'(r.minbit); i <= int'(r.maxbit); i++) begin
      w[i] = r.wdata[i - int'(r.minbit)];
    end
    if (c.v) begin
      for (int i = 0; i < int'(c.width); i++) begin
        w[int'(c.position) + i] = c.value[i];
      end
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus tasks
  // ----------------------------------------------------------------------
  task automatic run_init();
    int cycles;
    int busy_cycles;
    busy_cycles = 0;
    @(posedge clk);
    init_start <= 1'b1;
    @(posedge clk);
    init_start <= 1'b0;
    cycles = 1;
    @(negedge clk);
    while (!init_done && cycles < DEPTH + 20) begin
      if (init_busy) begin
        busy_cycles++;
      end
      @(negedge clk);
      cycles++;
    end
    if (!init_done) begin
      errors++;
      $display("init_done never pulsed after init_start");
    end
    check_value("init_done delay", DEPTH + 1, cycles);
    check_value("init_busy cycles", DEPTH, busy_cycles);
    for (int i = 0; i < DEPTH; i++) begin
      shadow[i] = '0;
    end
  endtask

  task automatic func_write(input logic [AWIDTH-1:0] addr, input logic [DWIDTH-1:0] data,
                            input logic inject);
    func_req_t r;
    r = '0;
    r.we = 1'b1;
    r.addr = addr;
    r.wdata = data;
    @(posedge clk);
    func <= r;
    err_inject <= inject;
    shadow[addr] = data;
    @(posedge clk);
    func <= '0;
    err_inject <= 1'b0;
  endtask

  task automatic func_read(input string name, input logic [AWIDTH-1:0] addr,
                           input logic exp_err);
    func_req_t r;
    r = '0;
    r.re = 1'b1;
    r.addr = addr;
    @(posedge clk);
    func <= r;
    @(posedge clk);
    func <= '0;
    @(negedge clk);
    check_value(name, shadow[addr], func_rdata);
    // every reader sees the returned word in the same cycle
    check_value({name, " init_rdata"}, shadow[addr], init_rdata);
    check_value({name, " rdata_error"}, exp_err, rdata_error);
  endtask

  // one read per cycle with each answer checked two cycles after its request
  task automatic cfg_read_burst();
    cfg_req_t              r;
    logic [CFG_DWIDTH-1:0] exp_field [N_CFG_RD];
    for (int i = 0; i < N_CFG_RD + 2; i++) begin
      @(posedge clk);
      if (i < N_CFG_RD) begin
        r = '0;
        r.re = 1'b1;
        r.addr = CFG_AWIDTH'($random(seed));
        r.minbit = BIT_IDX_W'(rand_range(0, DWIDTH - 1));
        r.maxbit = BIT_IDX_W'(rand_range(int'(r.minbit), DWIDTH - 1));
        exp_field[i] = field_bits(shadow[r.addr[AWIDTH-1:0]], int'(r.minbit),
                                  int'(r.maxbit));
        cfg <= r;
      end else begin
        cfg <= '0;
      end
      @(negedge clk);
      if (i >= 2) begin
        check_value($sformatf("cfg_read %0d ack", i - 2), 1, cfg_ack);
        check_value($sformatf("cfg_read %0d field", i - 2), exp_field[i - 2], cfg_rdata);
      end
    end
  endtask

  task automatic cfg_write_test(input logic cc_valid);
    cfg_req_t          r;
    cc_req_t           c;
    logic [AWIDTH-1:0] idx;
    logic [DWIDTH-1:0] expected;
    string             read_name;
    r = '0;
    r.we = 1'b1;
    r.addr = CFG_AWIDTH'($random(seed));
    r.minbit = BIT_IDX_W'(rand_range(0, 11));
    r.maxbit = BIT_IDX_W'(rand_range(int'(r.minbit), 11));
    r.wdata = $random(seed);
    c.v = cc_valid;
    c.value = CC_VWIDTH'($random(seed));
    c.width = CC_WWIDTH'(rand_range(1, CC_VWIDTH));
    c.position = BIT_IDX_W'(rand_range(12, DWIDTH - int'(c.width)));
    idx = r.addr[AWIDTH-1:0];
    expected = merged_word(shadow[idx], r, c);
    @(posedge clk);
    cfg <= r;
    cc <= c;
    @(posedge clk);
    cfg <= '0;
    cc <= '0;
    @(negedge clk);
    @(negedge clk);
    check_value("cfg_write ack", 1, cfg_ack);
    shadow[idx] = expected;
    if (cc_valid) begin
      read_name = "cfg_write with cc";
    end else begin
      read_name = "cfg_write no cc";
    end
    func_read(read_name, idx, 1'b0);
  endtask

  task automatic collision_test();
    func_req_t f;
    cfg_req_t  c;
    f = '0;
    f.re = 1'b1;
    f.addr = AWIDTH'(rand_range(0, DEPTH - 1));
    c = '0;
    c.re = 1'b1;
    c.addr = CFG_AWIDTH'(f.addr);
    c.maxbit = BIT_IDX_W'(DWIDTH - 1);
    @(posedge clk);
    func <= f;
    cfg <= c;
    @(posedge clk);
    func <= '0;
    cfg <= '0;
    @(negedge clk);
    check_value("collision error", 1, error);
    @(posedge clk);
    func <= f;
    @(posedge clk);
    func <= '0;
    @(negedge clk);
    check_value("single strobe error", 0, error);
    repeat (3) @(posedge clk);
  endtask

  task automatic parity_test();
    logic [AWIDTH-1:0] a;
    logic [DWIDTH-1:0] d;
    a = AWIDTH'(rand_range(0, DEPTH - 1));
    d = DWIDTH'($random(seed));
    func_write(a, d, 1'b1);
    func_read("parity inject", a, 1'b1);
    func_write(a, d, 1'b0);
    func_read("parity clean", a, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [AWIDTH-1:0] a;
    logic [DWIDTH-1:0] d;
    clk = 1'b0;
    rst_n = 1'b0;
    func = '0;
    cfg = '0;
    cc = '0;
    init_start = 1'b0;
    err_inject = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    run_init();
    for (int i = 0; i < N_FUNC; i++) begin
      func_read("init read", AWIDTH'(rand_range(0, DEPTH - 1)), 1'b0);
    end
    for (int i = 0; i < N_FUNC; i++) begin
      a = AWIDTH'(rand_range(0, DEPTH - 1));
      d = DWIDTH'($random(seed));
      func_write(a, d, 1'b0);
      func_read("func write", a, 1'b0);
    end
    cfg_read_burst();
    for (int i = 0; i < N_CFG_WR; i++) begin
      cfg_write_test(i[0]);
    end
    collision_test();
    parity_test();
    repeat (4) @(posedge clk);

    assert_fails = uut.u_access.u_assertions.fail_count;
    $display("checks done: %0d data errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- rfrw_sub.f
design/rfrw_pkg.sv
design/rfrw_ram.sv
design/rfrw_parity.sv
design/rfrw_init_seq.sv
design/rfrw_access.sv
design/rfrw_top.sv
verif/rfrw_assertions.sv
verif/rfrw_tb.sv
